//--- icache_config.svh
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// cache geometry
`define ICACHE_WAYS        2
`define ICACHE_SETS        128
`define ICACHE_BLOCK_WORDS 8
`define ICACHE_ADDR_W      32

// fetch address split: tag | index | pair | byte offset
`define ICACHE_TAG_W       20
`define ICACHE_INDEX_W     7
`define ICACHE_PAIR_W      2
`define ICACHE_OFFSET_W    3

`endif

//--- icache_pkg.sv
`include "icache_config.svh"

package icache_pkg;

    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]    tag;
        logic [`ICACHE_INDEX_W-1:0]  index;
        logic [`ICACHE_PAIR_W-1:0]   pair;
        logic [`ICACHE_OFFSET_W-1:0] offset;
    } fetch_fields_t;

    // same word, read raw or split into fields
    typedef union packed {
        logic [`ICACHE_ADDR_W-1:0] raw;
        fetch_fields_t             f;
    } fetch_addr_u;

    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0] tag;
        logic                     valid;
    } tag_entry_t;

    // one-hot way select, all zero means no way
    typedef logic [`ICACHE_WAYS-1:0] way_sel_t;

endpackage

//--- mem_port_pkg.sv
`include "icache_config.svh"

package mem_port_pkg;

    typedef logic [`ICACHE_ADDR_W-1:0] mem_addr_t;
    typedef logic [31:0]               mem_word_t;

    // words per memory read
    typedef logic [3:0] burst_len_t;

    typedef enum logic [2:0] {
        IDLE,
        MISS_REQ,
        MISS_DATA,
        UNC_REQ,
        UNC_DATA,
        INVAL
    } ctrl_state_e;

endpackage

//--- icache_array.sv
`timescale 1ns/1ns
`include "icache_config.svh"

module icache_array
    import icache_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  rd_en_i,
    input  logic [`ICACHE_INDEX_W-1:0]            rd_index_i,
    input  logic [`ICACHE_PAIR_W-1:0]             rd_pair_i,
    input  logic [`ICACHE_INDEX_W-1:0]            wr_index_i,
    input  logic [`ICACHE_PAIR_W-1:0]             wr_pair_i,
    input  way_sel_t                              wr_way_i,
    input  logic [63:0]                           wr_data_i,
    input  tag_entry_t                            wr_tag_i,
    input  logic                                  wr_tag_en_i,
    output tag_entry_t [`ICACHE_WAYS-1:0]         rd_tags_o,
    output logic [`ICACHE_WAYS-1:0][63:0]         rd_data_o
);

    localparam int unsigned ROW_W = `ICACHE_INDEX_W + `ICACHE_PAIR_W;
    localparam int unsigned ROWS  = `ICACHE_SETS * `ICACHE_BLOCK_WORDS / 2;

    logic [ROW_W-1:0] rd_row;
    logic [ROW_W-1:0] wr_row;

    assign rd_row = {rd_index_i, rd_pair_i};
    assign wr_row = {wr_index_i, wr_pair_i};

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        logic [`ICACHE_TAG_W-1:0] tag_mem [`ICACHE_SETS];
        logic [63:0]              data_mem [ROWS];
        logic [`ICACHE_SETS-1:0]  valid_q;
        tag_entry_t               tag_rd_q;
        logic [63:0]              data_rd_q;
        logic                     tag_we;
        logic                     data_we;

        assign data_we = wr_way_i[w];
        assign tag_we  = wr_way_i[w] && wr_tag_en_i;

        always_ff @(posedge clk) begin
            if (data_we) begin
                data_mem[wr_row] <= wr_data_i;
            end
            if (tag_we) begin
                tag_mem[wr_index_i] <= wr_tag_i.tag;
            end
        end

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                valid_q <= '0;
            end else if (tag_we) begin
                valid_q[wr_index_i] <= wr_tag_i.valid;
            end
        end

        // read port, same-row write is forwarded
        always_ff @(posedge clk) begin
            if (rd_en_i) begin
                if (tag_we && wr_index_i == rd_index_i) begin
                    tag_rd_q <= wr_tag_i;
                end else begin
                    tag_rd_q.tag   <= tag_mem[rd_index_i];
                    tag_rd_q.valid <= valid_q[rd_index_i];
                end
                if (data_we && wr_row == rd_row) begin
                    data_rd_q <= wr_data_i;
                end else begin
                    data_rd_q <= data_mem[rd_row];
                end
            end
        end

        assign rd_tags_o[w] = tag_rd_q;
        assign rd_data_o[w] = data_rd_q;
    end

    a_wr_way_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(wr_way_i));

endmodule

//--- icache_ctrl.sv
`timescale 1ns/1ns
`include "icache_config.svh"

module icache_ctrl
    import icache_pkg::*;
    import mem_port_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       lookup_valid_i,
    input  fetch_addr_u                lookup_addr_i,
    input  logic [1:0]                 lookup_mask_i,
    input  logic                       lookup_uncached_i,
    input  way_sel_t                   hit_way_i,
    input  logic [63:0]                hit_data_i,
    output logic                       mem_req_valid_o,
    input  logic                       mem_req_ready_i,
    output mem_addr_t                  mem_req_addr_o,
    output burst_len_t                 mem_req_len_o,
    input  logic                       mem_data_valid_i,
    input  mem_word_t                  mem_data_i,
    input  logic                       inval_valid_i,
    output logic                       inval_ready_o,
    input  logic [`ICACHE_INDEX_W-1:0] inval_index_i,
    input  logic                       inval_way_i,
    output logic [`ICACHE_INDEX_W-1:0] wr_index_o,
    output logic [`ICACHE_PAIR_W-1:0]  wr_pair_o,
    output way_sel_t                   wr_way_o,
    output logic [63:0]                wr_data_o,
    output tag_entry_t                 wr_tag_o,
    output logic                       wr_tag_en_o,
    output logic                       busy_o,
    output logic                       done_o,
    output logic [63:0]                done_insts_o
);

    localparam int unsigned CNT_W = $clog2(`ICACHE_BLOCK_WORDS);

    ctrl_state_e                state_q;
    ctrl_state_e                state_d;
    logic [CNT_W-1:0]           cnt_q;
    logic [`ICACHE_SETS-1:0]    toggle_q;
    logic [`ICACHE_INDEX_W-1:0] inval_index_q;
    logic                       inval_way_q;
    logic                       inval_rdy_q;
    logic [63:0]                buf_q;
    logic [63:0]                res_q;
    logic [63:0]                pair_now;
    logic                       lookup_hit;
    logic                       start_fill;
    logic                       start_unc;
    logic                       inval_fire;
    logic                       fill_word;
    logic                       fill_last;
    logic                       unc_last;
    way_sel_t                   fill_way;

    assign inval_ready_o = inval_rdy_q;
    assign inval_fire    = inval_valid_i && inval_ready_o;
    assign busy_o        = (state_q != IDLE) || inval_fire;

    // zero mask completes without memory access
    assign lookup_hit = lookup_uncached_i ? (lookup_mask_i == '0)
                                          : (|hit_way_i || lookup_mask_i == '0);
    assign start_fill = state_q == IDLE && lookup_valid_i && !lookup_uncached_i && !lookup_hit;
    assign start_unc  = state_q == IDLE && lookup_valid_i && lookup_uncached_i && !lookup_hit;

    assign fill_way  = way_sel_t'(1) << toggle_q[lookup_addr_i.f.index];
    assign fill_word = state_q == MISS_DATA && mem_data_valid_i;
    assign fill_last = fill_word && (&cnt_q);
    assign unc_last  = state_q == UNC_DATA && mem_data_valid_i && cnt_q[0] == lookup_mask_i[1];

    // incoming word merged into the pair buffer
    always_comb begin
        pair_now = buf_q;
        if (cnt_q[0]) begin
            pair_now[63:32] = mem_data_i;
        end else begin
            pair_now[31:0] = mem_data_i;
        end
    end

    assign mem_req_valid_o = start_fill || start_unc || state_q == MISS_REQ
                             || state_q == UNC_REQ;

    always_comb begin
        if (lookup_uncached_i) begin
            mem_req_addr_o = lookup_mask_i[0] ? lookup_addr_i.raw : lookup_addr_i.raw + 32'd4;
            mem_req_len_o  = burst_len_t'($countones(lookup_mask_i));
        end else begin
            mem_req_addr_o = {lookup_addr_i.f.tag, lookup_addr_i.f.index,
                              {(`ICACHE_PAIR_W + `ICACHE_OFFSET_W){1'b0}}};
            mem_req_len_o  = burst_len_t'(`ICACHE_BLOCK_WORDS);
        end
    end

    always_comb begin
        wr_index_o     = lookup_addr_i.f.index;
        wr_pair_o      = cnt_q[CNT_W-1:1];
        wr_way_o       = '0;
        wr_data_o      = pair_now;
        wr_tag_o.tag   = lookup_addr_i.f.tag;
        wr_tag_o.valid = 1'b1;
        wr_tag_en_o    = 1'b0;
        if (fill_word && cnt_q[0]) begin
            wr_way_o    = fill_way;
            wr_tag_en_o = fill_last;
        end else if (state_q == INVAL) begin
            wr_index_o  = inval_index_q;
            wr_way_o    = way_sel_t'(1) << inval_way_q;
            wr_tag_o    = '0;
            wr_tag_en_o = 1'b1;
        end
    end

    always_comb begin
        done_o       = 1'b0;
        done_insts_o = hit_data_i;
        if (state_q == IDLE) begin
            done_o = lookup_valid_i && lookup_hit;
        end else if (fill_last) begin
            done_o       = 1'b1;
            done_insts_o = (&lookup_addr_i.f.pair) ? pair_now : res_q;
        end else if (unc_last) begin
            done_o       = 1'b1;
            done_insts_o = pair_now;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (inval_fire) begin
                    state_d = INVAL;
                end else if (start_fill) begin
                    state_d = mem_req_ready_i ? MISS_DATA : MISS_REQ;
                end else if (start_unc) begin
                    state_d = mem_req_ready_i ? UNC_DATA : UNC_REQ;
                end
            end
            MISS_REQ:  if (mem_req_ready_i) state_d = MISS_DATA;
            MISS_DATA: if (fill_last) state_d = IDLE;
            UNC_REQ:   if (mem_req_ready_i) state_d = UNC_DATA;
            UNC_DATA:  if (unc_last) state_d = IDLE;
            default:   state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= IDLE;
            cnt_q       <= '0;
            toggle_q    <= '0;
            inval_rdy_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            inval_rdy_q <= state_d == IDLE;
            if (start_fill) begin
                cnt_q <= '0;
            end else if (start_unc) begin
                // first word slot skips a masked-off low word
                cnt_q <= CNT_W'(!lookup_mask_i[0]);
            end else if (mem_data_valid_i && (state_q == MISS_DATA || state_q == UNC_DATA)) begin
                cnt_q <= cnt_q + 1'b1;
            end
            if (fill_last) begin
                toggle_q[lookup_addr_i.f.index] <= !toggle_q[lookup_addr_i.f.index];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_data_valid_i) begin
            buf_q <= pair_now;
        end
        // requested pair as it streams past
        if (fill_word && cnt_q[0] && cnt_q[CNT_W-1:1] == lookup_addr_i.f.pair) begin
            res_q <= pair_now;
        end
        if (inval_fire) begin
            inval_index_q <= inval_index_i;
            inval_way_q   <= inval_way_i;
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid_o && !mem_req_ready_i |=>
            mem_req_valid_o && $stable(mem_req_addr_o) && $stable(mem_req_len_o));

endmodule

//--- icache_top.sv
`timescale 1ns/1ns
`include "icache_config.svh"

module icache_top
    import icache_pkg::*;
    import mem_port_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       fetch_valid_i,
    output logic                       fetch_ready_o,
    input  logic [`ICACHE_ADDR_W-1:0]  fetch_addr_i,
    input  logic [1:0]                 fetch_mask_i,
    input  logic                       fetch_uncached_i,
    output logic                       resp_valid_o,
    input  logic                       resp_ready_i,
    output logic [`ICACHE_ADDR_W-1:0]  resp_addr_o,
    output logic [1:0]                 resp_mask_o,
    output logic [63:0]                resp_insts_o,
    output logic                       mem_req_valid_o,
    input  logic                       mem_req_ready_i,
    output mem_addr_t                  mem_req_addr_o,
    output burst_len_t                 mem_req_len_o,
    input  logic                       mem_data_valid_i,
    input  mem_word_t                  mem_data_i,
    input  logic                       inval_valid_i,
    output logic                       inval_ready_o,
    input  logic [`ICACHE_INDEX_W-1:0] inval_index_i,
    input  logic                       inval_way_i
);

    fetch_addr_u                       fetch_addr;
    fetch_addr_u                       lk_addr;
    logic                              lk_valid;
    logic [1:0]                        lk_mask;
    logic                              lk_uncached;
    logic                              resp_free;
    logic                              fetch_fire;
    logic                              lookup_go;
    tag_entry_t [`ICACHE_WAYS-1:0]     rd_tags;
    logic [`ICACHE_WAYS-1:0][63:0]     rd_data;
    way_sel_t                          hit_way;
    logic [63:0]                       hit_data;
    logic [`ICACHE_INDEX_W-1:0]        wr_index;
    logic [`ICACHE_PAIR_W-1:0]         wr_pair;
    way_sel_t                          wr_way;
    logic [63:0]                       wr_data;
    tag_entry_t                        wr_tag;
    logic                              wr_tag_en;
    logic                              busy;
    logic                              done;
    logic [63:0]                       done_insts;
    logic                              ctrl_inval_ready;

    assign fetch_addr.raw = fetch_addr_i;

    // lookup only proceeds when its result has somewhere to go
    assign resp_free     = !resp_valid_o || resp_ready_i;
    assign lookup_go     = lk_valid && resp_free;
    assign fetch_ready_o = !busy && resp_free && (!lk_valid || done);
    assign fetch_fire    = fetch_valid_i && fetch_ready_o;
    assign inval_ready_o = ctrl_inval_ready && !lk_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lk_valid <= 1'b0;
        end else if (fetch_fire) begin
            lk_valid <= 1'b1;
        end else if (done) begin
            lk_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_fire) begin
            lk_addr.raw <= {fetch_addr_i[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W],
                            {`ICACHE_OFFSET_W{1'b0}}};
            lk_mask     <= fetch_mask_i;
            lk_uncached <= fetch_uncached_i;
        end
    end

    always_comb begin
        hit_data = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            hit_way[w] = rd_tags[w].valid && rd_tags[w].tag == lk_addr.f.tag;
            if (hit_way[w]) begin
                hit_data = hit_data | rd_data[w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid_o <= 1'b0;
        end else if (done) begin
            resp_valid_o <= 1'b1;
        end else if (resp_ready_i) begin
            resp_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            resp_addr_o  <= lk_addr.raw;
            resp_mask_o  <= lk_mask;
            resp_insts_o <= done_insts;
        end
    end

    icache_array u_array (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_en_i     (fetch_fire),
        .rd_index_i  (fetch_addr.f.index),
        .rd_pair_i   (fetch_addr.f.pair),
        .wr_index_i  (wr_index),
        .wr_pair_i   (wr_pair),
        .wr_way_i    (wr_way),
        .wr_data_i   (wr_data),
        .wr_tag_i    (wr_tag),
        .wr_tag_en_i (wr_tag_en),
        .rd_tags_o   (rd_tags),
        .rd_data_o   (rd_data)
    );

    icache_ctrl u_ctrl (
        .clk               (clk),
        .rst_n             (rst_n),
        .lookup_valid_i    (lookup_go),
        .lookup_addr_i     (lk_addr),
        .lookup_mask_i     (lk_mask),
        .lookup_uncached_i (lk_uncached),
        .hit_way_i         (hit_way),
        .hit_data_i        (hit_data),
        .mem_req_valid_o   (mem_req_valid_o),
        .mem_req_ready_i   (mem_req_ready_i),
        .mem_req_addr_o    (mem_req_addr_o),
        .mem_req_len_o     (mem_req_len_o),
        .mem_data_valid_i  (mem_data_valid_i),
        .mem_data_i        (mem_data_i),
        .inval_valid_i     (inval_valid_i && !lk_valid),
        .inval_ready_o     (ctrl_inval_ready),
        .inval_index_i     (inval_index_i),
        .inval_way_i       (inval_way_i),
        .wr_index_o        (wr_index),
        .wr_pair_o         (wr_pair),
        .wr_way_o          (wr_way),
        .wr_data_o         (wr_data),
        .wr_tag_o          (wr_tag),
        .wr_tag_en_o       (wr_tag_en),
        .busy_o            (busy),
        .done_o            (done),
        .done_insts_o      (done_insts)
    );

endmodule

//--- tb_icache_checker.sv
`timescale 1ns/1ns
`include "icache_config.svh"

module tb_icache_checker
    import mem_port_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        fetch_valid_i,
    input  logic        fetch_ready_i,
    input  logic [31:0] fetch_addr_i,
    input  logic [1:0]  fetch_mask_i,
    input  logic        fetch_uncached_i,
    input  logic        resp_valid_i,
    input  logic        resp_ready_i,
    input  logic [31:0] resp_addr_i,
    input  logic [1:0]  resp_mask_i,
    input  logic [63:0] resp_insts_i,
    input  logic        mem_req_valid_i,
    input  logic        mem_req_ready_i,
    input  logic [31:0] mem_req_addr_i,
    input  burst_len_t  mem_req_len_i,
    input  logic        inval_valid_i,
    input  logic        inval_ready_i,
    input  logic [6:0]  inval_index_i,
    input  logic        inval_way_i,
    output int unsigned err_count_o,
    output int unsigned resp_count_o
);

    logic [19:0] tag_q    [`ICACHE_WAYS][`ICACHE_SETS];
    logic        valid_q  [`ICACHE_WAYS][`ICACHE_SETS];
    logic        toggle_q [`ICACHE_SETS];
    logic [31:0] exp_addr_q [$];
    logic [1:0]  exp_mask_q [$];
    logic [31:0] req_addr_q [$];
    burst_len_t  req_len_q  [$];
    int unsigned req_seq_q  [$];
    int unsigned fetch_seq;
    int unsigned resp_seq;
    logic        held_q;
    logic [31:0] held_addr;
    logic [1:0]  held_mask;
    logic [63:0] held_insts;
    logic        in_reset_q;

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5ac3_0f96;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("error: %s expected %h actual %h", name, expected, actual);
            err_count_o++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("error: %s", what);
        err_count_o++;
    endtask

    task automatic check_response();
        logic [31:0] addr;
        logic [1:0]  mask;
        if (held_q) begin
            if (!resp_valid_i) begin
                report_failure("response dropped before it was taken");
            end
            check_value("hold_addr", 64'(held_addr), 64'(resp_addr_i));
            check_value("hold_mask", 64'(held_mask), 64'(resp_mask_i));
            check_value("hold_insts", held_insts, resp_insts_i);
        end
        if (resp_valid_i && !resp_ready_i && fetch_valid_i && fetch_ready_i) begin
            report_failure("fetch accepted while a response was held");
        end
        if (resp_valid_i && resp_ready_i) begin
            resp_count_o++;
            if (exp_addr_q.size() == 0) begin
                report_failure("response returned with no fetch outstanding");
            end else begin
                addr = exp_addr_q.pop_front();
                mask = exp_mask_q.pop_front();
                check_value("resp_addr", 64'(addr), 64'(resp_addr_i));
                check_value("resp_mask", 64'(mask), 64'(resp_mask_i));
                if (mask[0]) begin
                    check_value("resp_word0", 64'(word_at(addr)), 64'(resp_insts_i[31:0]));
                end
                if (mask[1]) begin
                    check_value("resp_word1", 64'(word_at(addr + 32'd4)),
                                64'(resp_insts_i[63:32]));
                end
                // requests of later fetches may already be queued
                if (req_seq_q.size() != 0 && req_seq_q[0] <= resp_seq) begin
                    report_failure("response returned before its memory request");
                end
                resp_seq++;
            end
        end
    endtask

    task automatic check_mem_request();
        logic [31:0] addr;
        burst_len_t  len;
        if (mem_req_valid_i && mem_req_ready_i) begin
            if (req_addr_q.size() == 0) begin
                report_failure("memory request issued with no miss outstanding");
            end else begin
                addr = req_addr_q.pop_front();
                len  = req_len_q.pop_front();
                void'(req_seq_q.pop_front());
                check_value("mem_req_addr", 64'(addr), 64'(mem_req_addr_i));
                check_value("mem_req_len", 64'(len), 64'(mem_req_len_i));
            end
        end
    endtask

    // model update on acceptance, refill into the toggle way
    task automatic track_fetch();
        logic [31:0] addr;
        logic [6:0]  set;
        logic        hit;
        logic        way;
        addr = {fetch_addr_i[31:3], 3'b000};
        set  = addr[11:5];
        exp_addr_q.push_back(addr);
        exp_mask_q.push_back(fetch_mask_i);
        if (fetch_mask_i != 2'b00 && fetch_uncached_i) begin
            req_addr_q.push_back(fetch_mask_i[0] ? addr : addr + 32'd4);
            req_len_q.push_back(4'(fetch_mask_i[0]) + 4'(fetch_mask_i[1]));
            req_seq_q.push_back(fetch_seq);
        end else if (fetch_mask_i != 2'b00) begin
            hit = 1'b0;
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if (valid_q[w][set] && tag_q[w][set] == addr[31:12]) begin
                    hit = 1'b1;
                end
            end
            if (!hit) begin
                way              = toggle_q[set];
                tag_q[way][set]   = addr[31:12];
                valid_q[way][set] = 1'b1;
                toggle_q[set]    = !toggle_q[set];
                req_addr_q.push_back({addr[31:5], 5'b00000});
                req_len_q.push_back(burst_len_t'(`ICACHE_BLOCK_WORDS));
                req_seq_q.push_back(fetch_seq);
            end
        end
        fetch_seq++;
    endtask

    task automatic clear_model();
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            toggle_q[s] = 1'b0;
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                valid_q[w][s] = 1'b0;
            end
        end
        exp_addr_q.delete();
        exp_mask_q.delete();
        req_addr_q.delete();
        req_len_q.delete();
        req_seq_q.delete();
        fetch_seq    = 0;
        resp_seq     = 0;
        held_q       = 1'b0;
        err_count_o  = 0;
        resp_count_o = 0;
    endtask

    // handshakes complete on the next rising edge
    always @(negedge clk) begin
        if (!rst_n) begin
            clear_model();
        end else begin
            if (in_reset_q) begin
                check_value("reset_fetch_ready", 64'd1, 64'(fetch_ready_i));
                check_value("reset_resp_valid", 64'd0, 64'(resp_valid_i));
                check_value("reset_mem_req_valid", 64'd0, 64'(mem_req_valid_i));
                check_value("reset_inval_ready", 64'd0, 64'(inval_ready_i));
            end
            check_response();
            check_mem_request();
            if (inval_valid_i && inval_ready_i) begin
                valid_q[inval_way_i][inval_index_i] = 1'b0;
            end
            if (fetch_valid_i && fetch_ready_i) begin
                track_fetch();
            end
            held_q     = resp_valid_i && !resp_ready_i;
            held_addr  = resp_addr_i;
            held_mask  = resp_mask_i;
            held_insts = resp_insts_i;
        end
        in_reset_q = !rst_n;
    end

endmodule

//--- tb_icache_top.sv
`timescale 1ns/1ns

module tb_icache_top;

    localparam int unsigned N_TRANS        = 400;
    localparam int unsigned TIMEOUT_CYCLES = N_TRANS * 40 + 200;

    logic        clk;
    logic        rst_n;
    logic        fetch_valid;
    logic        fetch_ready;
    logic [31:0] fetch_addr;
    logic [1:0]  fetch_mask;
    logic        fetch_uncached;
    logic        resp_valid;
    logic        resp_ready;
    logic [31:0] resp_addr;
    logic [1:0]  resp_mask;
    logic [63:0] resp_insts;
    logic        mem_req_valid;
    logic        mem_req_ready;
    logic [31:0] mem_req_addr;
    logic [3:0]  mem_req_len;
    logic        mem_data_valid;
    logic [31:0] mem_data;
    logic        inval_valid;
    logic        inval_ready;
    logic [6:0]  inval_index;
    logic        inval_way;
    int unsigned err_count;
    int unsigned resp_count;

    // handshakes seen at the falling edge, memory burst state
    int unsigned sent;
    logic        fetch_taken;
    logic        inval_taken;
    logic [31:0] mem_addr_q;
    int unsigned mem_left;

    // memory content as a fixed function of the byte address
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5ac3_0f96;
    endfunction

    // four sets, four tags each, so two ways keep conflicting
    function automatic logic [6:0] pick_index();
        return 7'($urandom_range(0, 3)) * 7'd37;
    endfunction

    task automatic drive_fetch();
        logic [19:0] tag;
        if (fetch_taken) begin
            fetch_valid = 1'b0;
        end
        if (!fetch_valid && sent < N_TRANS && $urandom_range(0, 3) != 0) begin
            tag            = 20'h4_2000 + 20'($urandom_range(0, 3));
            fetch_valid    = 1'b1;
            fetch_addr     = {tag, pick_index(), 2'($urandom_range(0, 3)), 3'($urandom_range(0, 7))};
            fetch_mask     = 2'($urandom_range(0, 3));
            fetch_uncached = $urandom_range(0, 5) == 0;
        end
    endtask

    task automatic drive_inval();
        if (inval_taken) begin
            inval_valid = 1'b0;
        end
        if (!inval_valid && sent < N_TRANS && $urandom_range(0, 15) == 0) begin
            inval_valid = 1'b1;
            inval_index = pick_index();
            inval_way   = 1'($urandom_range(0, 1));
        end
    endtask

    // words come back in address order with random gaps
    task automatic drive_memory();
        mem_req_ready = $urandom_range(0, 2) != 0;
        if (mem_left != 0 && $urandom_range(0, 3) != 0) begin
            mem_data_valid = 1'b1;
            mem_data       = word_at(mem_addr_q);
        end else begin
            mem_data_valid = 1'b0;
        end
    endtask

    task automatic sample_handshakes();
        fetch_taken = fetch_valid && fetch_ready;
        inval_taken = inval_valid && inval_ready;
        if (fetch_taken) begin
            sent++;
        end
        if (mem_data_valid) begin
            mem_addr_q = mem_addr_q + 32'd4;
            mem_left   = mem_left - 1;
        end
        if (mem_req_valid && mem_req_ready) begin
            mem_addr_q = mem_req_addr;
            mem_left   = mem_req_len;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    initial begin : stimulus
        void'($urandom(45));
        rst_n          = 1'b0;
        fetch_valid    = 1'b0;
        fetch_addr     = '0;
        fetch_mask     = '0;
        fetch_uncached = 1'b0;
        resp_ready     = 1'b0;
        mem_req_ready  = 1'b0;
        mem_data_valid = 1'b0;
        mem_data       = '0;
        inval_valid    = 1'b0;
        inval_index    = '0;
        inval_way      = 1'b0;
        sent           = 0;
        fetch_taken    = 1'b0;
        inval_taken    = 1'b0;
        mem_addr_q     = '0;
        mem_left       = 0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        while (resp_count < N_TRANS) begin
            drive_fetch();
            drive_inval();
            drive_memory();
            resp_ready = $urandom_range(0, 3) != 0;
            @(negedge clk);
            sample_handshakes();
            @(posedge clk);
            #2;
        end
        fetch_valid = 1'b0;
        inval_valid = 1'b0;
        repeat (2) @(posedge clk);
        $display("checks done: %0d responses, %0d errors", resp_count, err_count);
        if (err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("run timed out with %0d of %0d responses returned", resp_count, N_TRANS);
        $display("checks done: %0d responses, %0d errors", resp_count, err_count);
        $display("test failed");
        $finish;
    end

    icache_top dut_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .fetch_valid_i    (fetch_valid),
        .fetch_ready_o    (fetch_ready),
        .fetch_addr_i     (fetch_addr),
        .fetch_mask_i     (fetch_mask),
        .fetch_uncached_i (fetch_uncached),
        .resp_valid_o     (resp_valid),
        .resp_ready_i     (resp_ready),
        .resp_addr_o      (resp_addr),
        .resp_mask_o      (resp_mask),
        .resp_insts_o     (resp_insts),
        .mem_req_valid_o  (mem_req_valid),
        .mem_req_ready_i  (mem_req_ready),
        .mem_req_addr_o   (mem_req_addr),
        .mem_req_len_o    (mem_req_len),
        .mem_data_valid_i (mem_data_valid),
        .mem_data_i       (mem_data),
        .inval_valid_i    (inval_valid),
        .inval_ready_o    (inval_ready),
        .inval_index_i    (inval_index),
        .inval_way_i      (inval_way)
    );

    tb_icache_checker u_check (
        .clk              (clk),
        .rst_n            (rst_n),
        .fetch_valid_i    (fetch_valid),
        .fetch_ready_i    (fetch_ready),
        .fetch_addr_i     (fetch_addr),
        .fetch_mask_i     (fetch_mask),
        .fetch_uncached_i (fetch_uncached),
        .resp_valid_i     (resp_valid),
        .resp_ready_i     (resp_ready),
        .resp_addr_i      (resp_addr),
        .resp_mask_i      (resp_mask),
        .resp_insts_i     (resp_insts),
        .mem_req_valid_i  (mem_req_valid),
        .mem_req_ready_i  (mem_req_ready),
        .mem_req_addr_i   (mem_req_addr),
        .mem_req_len_i    (mem_req_len),
        .inval_valid_i    (inval_valid),
        .inval_ready_i    (inval_ready),
        .inval_index_i    (inval_index),
        .inval_way_i      (inval_way),
        .err_count_o      (err_count),
        .resp_count_o     (resp_count)
    );

endmodule

//--- compile.f
+incdir+.
icache_pkg.sv
mem_port_pkg.sv
icache_array.sv
icache_ctrl.sv
icache_top.sv
tb_icache_checker.sv
tb_icache_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_icache_top -o sim_icache

./obj_dir/sim_icache > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "test failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"
